//--- build.f
+incdir+src
src/counter_pkg.sv
src/counter_slice_if.sv
src/presettable_slice.sv
src/cascade_counter.sv
src/updown_counter.sv
src/snapshot_counter.sv
src/counter_bank_top.sv
verif/counter_bank_tb.sv

//--- Bender.yml
package:
  name: counter_bank

export_include_dirs:
  - src

sources:
  - include_dirs:
      - src
    files:
      - src/counter_pkg.sv
      - src/counter_slice_if.sv
      - src/presettable_slice.sv
      - src/cascade_counter.sv
      - src/updown_counter.sv
      - src/snapshot_counter.sv
      - src/counter_bank_top.sv
      - target: test
        files:
          - verif/counter_bank_tb.sv

//--- verif/counter_bank_tb.sv
// Counter bank testbench

`timescale 1ns/1ps

module counter_bank_tb import counter_pkg::*; ();

   // Rough cycle count of all tests plus a watchdog margin
   localparam int TEST_CYCLES = 6 + 201 + 8 + 212 + 301 + 259;
   localparam int WATCHDOG_NS = (TEST_CYCLES + 100) * 20;

   typedef struct packed {
      logic    carry;
      logic    borrow;
      updown_t q;
   } ud_state_t;

   typedef struct packed {
      snapshot_t count;   // Running count
      snapshot_t store;   // Storage register
   } sc_state_t;

   logic      clk, arst_n;
   logic      chain_load_n, chain_cet, chain_cep, chain_tc;
   chain_t    chain_p, chain_q;
   logic      ud_clear, ud_load_n, ud_up, ud_down, ud_carry, ud_borrow;
   updown_t   ud_p, ud_q;
   logic      sc_en, sc_clr, sc_rck, sc_oe, sc_rco;
   snapshot_t sc_q;

   chain_t      chain_exp;                    // Shadow states
   ud_state_t   ud_exp;
   sc_state_t   sc_exp;
   logic [15:0] lfsr_state;
   int          errors, tests_passed, tests_failed, mark;

   counter_bank_top UUT (.*);

   initial begin : clock_gen
      clk = 1'b0;
      forever #10 clk = ~clk;                 // 20 ns period
   end

   ////////////////////////////////////////////////////////////////////////////
   // Random bits and reference models
   ////////////////////////////////////////////////////////////////////////////

   // x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [15:0] lfsr_next(input logic [15:0] s);
      return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
   endfunction

   function automatic logic [15:0] take_bits(input int n);
      logic [15:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr_state = lfsr_next(lfsr_state);  // One step per bit
         r = {r[14:0], lfsr_state[0]};
      end
      return r;
   endfunction

   // Load over count and count needs both enables
   function automatic chain_t chain_model(chain_t q, logic load_n, logic cet, logic cep,
                                          chain_t p);
      if (!load_n) return p;
      if (cet && cep) return chain_t'(q + 1'b1);
      return q;
   endfunction

   function automatic ud_state_t updown_model(ud_state_t s, logic clear, logic load_n,
                                              updown_t p, logic up, logic down);
      if (clear) return '0;
      if (!load_n) return {2'b00, p};
      if (up && !down) return {(s.q == 4'hF), 1'b0, updown_t'(s.q + 1'b1)};
      if (down && !up) return {1'b0, (s.q == 4'h0), updown_t'(s.q - 1'b1)};
      return {2'b00, s.q};                    // Both strobes or neither
   endfunction

   function automatic sc_state_t snapshot_model(sc_state_t s, logic en, logic clr, logic rck);
      sc_state_t n;
      n = s;
      if (rck) n.store = s.count;             // Count from before the edge
      if (clr) n.count = '0;
      else if (en) n.count = snapshot_t'(s.count + 1'b1);
      return n;
   endfunction

   ////////////////////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////////////////////

   task automatic check_value(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
      assert (actual === expected) else begin
         errors++;
         $display("Mismatch at %0t ns: %s expected %0h, actual %0h",
                  $time, name, expected, actual);
      end
   endtask

   task automatic drive_idle();
      {chain_load_n, chain_cet, chain_cep, chain_p} = {3'b100, 16'h0000};
      {ud_clear, ud_load_n, ud_up, ud_down, ud_p} = {4'b0100, 4'h0};
      {sc_en, sc_clr, sc_rck, sc_oe} = 4'b0000;
   endtask

   task automatic drive_chain(input logic load_n, input logic cet, input logic cep,
                              input chain_t p);
      @(negedge clk);
      {chain_load_n, chain_cet, chain_cep, chain_p} = {load_n, cet, cep, p};
   endtask

   task automatic drive_ud(input logic clear, input logic load_n, input updown_t p,
                           input logic up, input logic down);
      @(negedge clk);
      {ud_clear, ud_load_n, ud_p, ud_up, ud_down} = {clear, load_n, p, up, down};
   endtask

   task automatic end_test(input string name);
      if (errors == mark) begin
         tests_passed++;
         $display("Test %-24s passed", name);
      end else begin
         tests_failed++;
         $display("Test %-24s failed, %0d errors", name, errors - mark);
      end
      mark = errors;
   endtask

   ////////////////////////////////////////////////////////////////////////////
   // Compare just after every rising edge
   ////////////////////////////////////////////////////////////////////////////

   initial begin : compare
      forever begin
         @(posedge clk);
         if (!arst_n) begin
            chain_exp = '0;
            ud_exp    = '0;
            sc_exp    = '0;
         end else begin                       // Inputs still hold their pre-edge values
            chain_exp = chain_model(chain_exp, chain_load_n, chain_cet, chain_cep, chain_p);
            ud_exp    = updown_model(ud_exp, ud_clear, ud_load_n, ud_p, ud_up, ud_down);
            sc_exp    = snapshot_model(sc_exp, sc_en, sc_clr, sc_rck);
         end
         #1;
         check_value("chain_q", chain_exp, chain_q);
         check_value("chain_tc", (&chain_exp) && chain_cet, chain_tc);
         check_value("ud_q", ud_exp.q, ud_q);
         check_value("ud_carry", ud_exp.carry, ud_carry);
         check_value("ud_borrow", ud_exp.borrow, ud_borrow);
         check_value("sc_q", sc_oe ? sc_exp.store : 8'h00, sc_q);
         check_value("sc_rco", (&sc_exp.count) && sc_en, sc_rco);
         assert (!(ud_carry && ud_borrow)) else begin
            errors++;
            $display("Error at %0t ns: ud_carry and ud_borrow are high together", $time);
         end
      end
   end

   initial begin : watchdog
      #(WATCHDOG_NS);
      $display("Timeout: tests still running after %0d ns", WATCHDOG_NS);
      $display(">>> FAIL");
      $finish;
   end

   ////////////////////////////////////////////////////////////////////////////
   // Stimulus
   ////////////////////////////////////////////////////////////////////////////

   initial begin : stimulus
      {errors, tests_passed, tests_failed, mark} = '0;
      lfsr_state = 16'd16285;
      arst_n     = 1'b0;
      drive_idle();

      repeat (4) @(negedge clk);              // Four edges in reset
      arst_n = 1'b1;
      repeat (2) @(negedge clk);
      end_test("reset state");

      for (int i = 0; i < 200; i++) begin
         drive_chain(take_bits(3) != 0, take_bits(2) != 0, take_bits(2) != 0, take_bits(16));
      end
      @(negedge clk);
      drive_idle();
      end_test("cascade random");

      drive_chain(1'b0, 1'b0, 1'b0, 16'hFFFD);
      drive_chain(1'b1, 1'b1, 1'b1, '0);      // FFFE
      drive_chain(1'b1, 1'b1, 1'b1, '0);      // FFFF
      drive_chain(1'b1, 1'b0, 1'b1, '0);      // tc gated off by cet
      drive_chain(1'b1, 1'b1, 1'b0, '0);      // tc high but cep holds
      drive_chain(1'b1, 1'b1, 1'b1, '0);      // Wrap
      drive_chain(1'b1, 1'b0, 1'b0, '0);
      check_value("chain_q", 16'h0000, chain_q);
      @(negedge clk);
      end_test("cascade ripple");

      for (int i = 0; i < 200; i++) begin
         drive_ud(take_bits(3) == 0, take_bits(3) != 0, updown_t'(take_bits(4)),
                  take_bits(1) != 0, take_bits(1) != 0);
      end
      drive_ud(1'b0, 1'b0, 4'hE, 1'b0, 1'b0);
      drive_ud(1'b0, 1'b1, 4'h0, 1'b1, 1'b0);
      drive_ud(1'b0, 1'b1, 4'h0, 1'b1, 1'b0); // 15 -> 0
      drive_ud(1'b0, 1'b1, 4'h0, 1'b0, 1'b0);
      check_value("ud_carry", 1, ud_carry);
      drive_ud(1'b0, 1'b0, 4'h1, 1'b0, 1'b0);
      check_value("ud_carry", 0, ud_carry);   // Single cycle pulse
      drive_ud(1'b0, 1'b1, 4'h0, 1'b0, 1'b1);
      drive_ud(1'b0, 1'b1, 4'h0, 1'b0, 1'b1); // 0 -> 15
      drive_ud(1'b0, 1'b1, 4'h0, 1'b0, 1'b0);
      check_value("ud_borrow", 1, ud_borrow);
      drive_ud(1'b0, 1'b1, 4'h0, 1'b0, 1'b0);
      check_value("ud_borrow", 0, ud_borrow);
      @(negedge clk);
      end_test("up/down counter");

      // Rare clears let the count run long
      for (int i = 0; i < 300; i++) begin
         @(negedge clk);
         sc_en  = (take_bits(3) != 0);
         sc_clr = (take_bits(8) == 0);
         sc_rck = (take_bits(2) == 0);
         sc_oe  = (take_bits(1) != 0);
      end

      // Clear, then a full run through 255 and the wrap
      @(negedge clk);
      {sc_en, sc_clr, sc_rck, sc_oe} = 4'b0101;
      repeat (257) begin
         @(negedge clk);
         {sc_en, sc_clr, sc_rck, sc_oe} = 4'b1001;
      end
      @(negedge clk);
      drive_idle();
      end_test("snapshot counter");

      $display("Tests passed %0d, failed %0d, mismatches %0d",
               tests_passed, tests_failed, errors);
      if (errors == 0) begin
         $display(">>> PASS");
      end else begin
         $display(">>> FAIL");
      end
      $finish;
   end

endmodule

//--- src/counter_bank_top.sv
// Counter bank top level

`timescale 1ns/1ps

`include "counter_config.svh"

module counter_bank_top import counter_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,

   // Cascade counter
   input  logic      chain_load_n,
   input  logic      chain_cet,
   input  logic      chain_cep,
   input  chain_t    chain_p,
   output chain_t    chain_q,
   output logic      chain_tc,

   // Up/down counter
   input  logic      ud_clear,
   input  logic      ud_load_n,
   input  updown_t   ud_p,
   input  logic      ud_up,
   input  logic      ud_down,
   output updown_t   ud_q,
   output logic      ud_carry,
   output logic      ud_borrow,

   // Snapshot counter
   input  logic      sc_en,
   input  logic      sc_clr,
   input  logic      sc_rck,
   input  logic      sc_oe,
   output snapshot_t sc_q,
   output logic      sc_rco
);

   ////////////////////////////////////////////////////////////////////////////
   // 161-style cascade
   ////////////////////////////////////////////////////////////////////////////

   cascade_counter u_cascade (
      .clk    (clk),
      .arst_n (arst_n),
      .load_n (chain_load_n),
      .cet    (chain_cet),
      .cep    (chain_cep),
      .p      (chain_p),
      .q      (chain_q),
      .tc     (chain_tc)
   );

   ////////////////////////////////////////////////////////////////////////////
   // 193-style up/down
   ////////////////////////////////////////////////////////////////////////////

   updown_counter u_updown (
      .clk    (clk),
      .arst_n (arst_n),
      .clear  (ud_clear),
      .load_n (ud_load_n),
      .p      (ud_p),
      .up     (ud_up),
      .down   (ud_down),
      .q      (ud_q),
      .carry  (ud_carry),
      .borrow (ud_borrow)
   );

   ////////////////////////////////////////////////////////////////////////////
   // 590-style snapshot
   ////////////////////////////////////////////////////////////////////////////

   snapshot_counter u_snapshot (
      .clk    (clk),
      .arst_n (arst_n),
      .en     (sc_en),
      .clr    (sc_clr),
      .rck    (sc_rck),
      .oe     (sc_oe),
      .q      (sc_q),
      .rco    (sc_rco)
   );

endmodule

//--- src/snapshot_counter.sv
// 8-bit counter with storage register

`timescale 1ns/1ps

`include "counter_config.svh"

module snapshot_counter import counter_pkg::*; (
   input  logic      clk,
   input  logic      arst_n,
   input  logic      en,    // Count enable
   input  logic      clr,   // Synchronous clear, over en
   input  logic      rck,   // Snapshot strobe
   input  logic      oe,    // Output enable
   output snapshot_t q,     // Stored value, zero when disabled
   output logic      rco    // Ripple carry
);

   snapshot_t count;   // Running count
   snapshot_t store;   // Storage register

   ////////////////////////////////////////////////////////////////////////////
   // Counter stage
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (clr) begin
         count <= '0;
      end else if (en) begin
         count <= count + 1'b1;   // Wraps 255 -> 0
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Storage stage
   ////////////////////////////////////////////////////////////////////////////

   // Samples count as it stood before this edge
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         store <= '0;
      end else if (rck) begin
         store <= count;
      end
   end

   assign q = oe ? store : '0;   // Disabled output reads zero

   // Ripple carry from the count itself, not from zero as on the old model
   assign rco = (&count) && en;

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Snapshot is only refreshed by rck
   a_store_holds : assert property (
      @(posedge clk) disable iff (!arst_n)
      !rck |=> $stable(store)
   )
   else $error("snapshot_counter: storage changed without rck");

endmodule

//--- src/updown_counter.sv
// 4-bit up/down counter with carry and borrow

`timescale 1ns/1ps

`include "counter_config.svh"

module updown_counter import counter_pkg::*; (
   input  logic    clk,
   input  logic    arst_n,
   input  logic    clear,    // Synchronous clear, active high
   input  logic    load_n,   // Parallel load, active low
   input  updown_t p,
   input  logic    up,       // Count up strobe
   input  logic    down,     // Count down strobe
   output updown_t q,
   output logic    carry,    // One cycle on 15 -> 0
   output logic    borrow    // One cycle on 0 -> 15
);

   logic step_up;     // Up alone
   logic step_down;   // Down alone

   // Both strobes together cancel out and hold
   assign step_up   = up && !down;
   assign step_down = down && !up;

   ////////////////////////////////////////////////////////////////////////////
   // Count and wrap flags
   ////////////////////////////////////////////////////////////////////////////

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         q      <= '0;
         carry  <= 1'b0;
         borrow <= 1'b0;
      end else begin
         // Flags are pulses, cleared unless this edge wraps
         carry  <= 1'b0;
         borrow <= 1'b0;

         if (clear) begin
            q <= '0;                     // Clear wins over everything
         end else if (!load_n) begin
            q <= p;
         end else if (step_up) begin
            q     <= q + 1'b1;
            carry <= (q == '1);          // Wrap to zero shows next cycle
         end else if (step_down) begin
            q      <= q - 1'b1;
            borrow <= (q == '0);         // Wrap to all ones
         end
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   a_no_carry_and_borrow : assert property (
      @(posedge clk) disable iff (!arst_n)
      !(carry && borrow)
   )
   else $error("updown_counter: carry and borrow high together");

   // Carry only ever marks a real rollover from the previous cycle
   a_carry_is_wrap : assert property (
      @(posedge clk) disable iff (!arst_n)
      carry |-> ($past(q) == '1) && (q == '0)
   )
   else $error("updown_counter: carry without 15 to 0 wrap");

endmodule

//--- src/cascade_counter.sv
// 16-bit cascaded presettable counter

`timescale 1ns/1ps

`include "counter_config.svh"

module cascade_counter import counter_pkg::*; (
   input  logic   clk,
   input  logic   arst_n,
   input  logic   load_n,   // Shared parallel load, active low
   input  logic   cet,      // Enters slice 0 only
   input  logic   cep,      // Shared by every slice
   input  chain_t p,        // Preset, one nibble per slice
   output chain_t q,
   output logic   tc        // Last slice terminal count
);

   localparam int SW = `COUNTER_SLICE_WIDTH;
   localparam int NS = `COUNTER_CHAIN_SLICES;

   counter_slice_if slice_bus [NS] ();   // One bundle per slice

   ////////////////////////////////////////////////////////////////////////////
   // Slice chain
   ////////////////////////////////////////////////////////////////////////////

   for (genvar i = 0; i < NS; i++) begin : g_slice
      assign slice_bus[i].load_n = load_n;
      assign slice_bus[i].cep    = cep;
      assign slice_bus[i].p      = p[i*SW +: SW];   // Own nibble

      // Ripple enable from the slice below
      if (i == 0) begin : g_first
         assign slice_bus[i].cet = cet;
      end else begin : g_next
         assign slice_bus[i].cet = slice_bus[i-1].tc;
      end

      presettable_slice u_slice (
         .clk    (clk),
         .arst_n (arst_n),
         .bus    (slice_bus[i])
      );

      assign q[i*SW +: SW] = slice_bus[i].q;   // Reassemble the count
   end

   // High only with the whole chain at all ones and cet high
   assign tc = slice_bus[NS-1].tc;

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // Full enables step the whole chain by one, through every ripple
   a_chain_step : assert property (
      @(posedge clk) disable iff (!arst_n)
      (load_n && cet && cep) |=> (q == chain_t'($past(q) + 1'b1))
   )
   else $error("cascade_counter: chain did not advance by one");

endmodule

//--- src/presettable_slice.sv
// 4-bit presettable counter slice

`timescale 1ns/1ps

`include "counter_config.svh"

module presettable_slice import counter_pkg::*; (
   input logic            clk,
   input logic            arst_n,
   counter_slice_if.slice bus
);

   slice_t count;   // Slice register

   ////////////////////////////////////////////////////////////////////////////
   // Count register
   ////////////////////////////////////////////////////////////////////////////

   // Reset, then load, then count, else hold
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         count <= '0;
      end else if (!bus.load_n) begin
         count <= bus.p;                // Parallel load beats counting
      end else if (bus.cet && bus.cep) begin
         count <= count + 1'b1;         // Wraps 15 -> 0
      end
   end

   ////////////////////////////////////////////////////////////////////////////
   // Outputs
   ////////////////////////////////////////////////////////////////////////////

   assign bus.q = count;

   // Terminal count qualified by cet, as on the real part,
   // so the next slice only sees it when this one may roll over
   assign bus.tc = (&count) && bus.cet;

   ////////////////////////////////////////////////////////////////////////////
   // Checks
   ////////////////////////////////////////////////////////////////////////////

   // A counting terminal count sits on all ones and rolls to zero next
   a_tc_wrap : assert property (
      @(posedge clk) disable iff (!arst_n)
      (bus.tc && bus.cep && bus.load_n) |-> (&bus.q) ##1 (bus.q == '0)
   )
   else $error("presettable_slice: tc not followed by wrap to zero");

endmodule

//--- src/counter_slice_if.sv
// Presettable slice bundle

`timescale 1ns/1ps

`include "counter_config.svh"

interface counter_slice_if import counter_pkg::*; ();

   // Controls, levels sampled on clk
   logic   load_n;   // Active low parallel load
   logic   cet;      // Count enable, also gates tc
   logic   cep;      // Count enable, parallel
   slice_t p;        // Preset value

   // Slice state
   slice_t q;        // Current count
   logic   tc;       // Terminal count, combinational

   // Chain side drives the controls and watches the count
   modport chain (
      output load_n, cet, cep, p,
      input  q, tc
   );

   // The slice itself
   modport slice (
      input  load_n, cet, cep, p,
      output q, tc
   );

endinterface

//--- src/counter_pkg.sv
// Counter bank types

`include "counter_config.svh"

package counter_pkg;

   ////////////////////////////////////////////////////////////////////////////
   // Cascade values
   ////////////////////////////////////////////////////////////////////////////

   // One presettable slice
   typedef logic [`COUNTER_SLICE_WIDTH-1:0] slice_t;

   // Whole chain, slice 0 in the low nibble
   typedef logic [`COUNTER_SLICE_WIDTH*`COUNTER_CHAIN_SLICES-1:0] chain_t;

   ////////////////////////////////////////////////////////////////////////////
   // Standalone counters
   ////////////////////////////////////////////////////////////////////////////

   typedef logic [`COUNTER_UPDOWN_WIDTH-1:0] updown_t;     // Up/down value

   // Count and storage register share this width
   typedef logic [`COUNTER_SNAPSHOT_WIDTH-1:0] snapshot_t;

endpackage

//--- src/counter_config.svh
// Counter bank configuration

`ifndef COUNTER_CONFIG_SVH
`define COUNTER_CONFIG_SVH

////////////////////////////////////////////////////////////////////////////
// Cascade counter geometry
////////////////////////////////////////////////////////////////////////////

`define COUNTER_SLICE_WIDTH    4   // Bits per 161-style slice
`define COUNTER_CHAIN_SLICES   4   // Slices in the ripple chain

////////////////////////////////////////////////////////////////////////////
// Standalone counters
////////////////////////////////////////////////////////////////////////////

`define COUNTER_UPDOWN_WIDTH   4   // 193-style up/down counter
`define COUNTER_SNAPSHOT_WIDTH 8   // 590-style counter and storage register

`endif
